/* common/periph_pkg.sv */
`default_nettype none

package periph_pkg;

  // clocks per oversample tick, kept small to speed up simulation
  localparam int CLK_DIV = 4;
  // width of the tick divider
  localparam int DIV_W = $clog2(CLK_DIV);
  // oversample ticks per serial bit
  localparam int OS_RATE = 16;

  // serial payload byte
  typedef logic [7:0] byte_t;
  // led output register
  typedef logic [7:0] led_t;
  // dip switch inputs
  typedef logic [3:0] sw_t;
  // tick position inside one bit
  typedef logic [3:0] os_cnt_t;
  // bit position inside one frame
  typedef logic [3:0] bit_cnt_t;

  // command decoder states
  typedef enum logic [1:0] {
    ST_IDLE,
    ST_WAIT_DATA,
    ST_SEND,
    ST_WAIT_TX
  } cmd_state_t;

  // host command bytes
  localparam byte_t CMD_LED_WR = 8'h4C;
  localparam byte_t CMD_LED_RD = 8'h52;
  localparam byte_t CMD_SW_RD  = 8'h53;

  // reply codes
  localparam byte_t RSP_ACK = 8'h06;
  localparam byte_t RSP_NAK = 8'h15;

endpackage

`default_nettype wire

/* hdl/baud_timer.sv */
`timescale 1ns/10ps
`default_nettype none

module baud_timer (
  input  logic clk,
  input  logic i_arst_n,
  output logic o_os_tick
);

  import periph_pkg::*;

  // down-counter, one tick per wrap
  logic [DIV_W-1:0] div_cnt;

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      div_cnt   <= DIV_W'(CLK_DIV - 1);
      o_os_tick <= 1'b0;
    end else begin
      if (div_cnt == '0) begin
        // wrapped, reload and fire the tick
        div_cnt   <= DIV_W'(CLK_DIV - 1);
        o_os_tick <= 1'b1;
      end else begin
        div_cnt   <= div_cnt - 1'b1;
        o_os_tick <= 1'b0;
      end
    end
  end

  // tick is a single-clock pulse
  // both uart directions share it as their time base

endmodule

`default_nettype wire

/* uart/uart_rx.sv */
`timescale 1ns/10ps
`default_nettype none

module uart_rx (
  input  logic              clk,
  input  logic              i_arst_n,
  input  logic              i_os_tick,
  input  logic              i_rx,
  output periph_pkg::byte_t o_rx_data,
  output logic              o_rx_valid,
  output logic              o_frame_err
);

  import periph_pkg::*;

  // two-flop synchronizer plus previous value for edge detect
  logic     rx_meta;
  logic     rx_sync;
  logic     rx_prev;
  // frame in progress
  logic     rx_busy;
  os_cnt_t  os_cnt;
  // 0 is the start bit, 1..8 data, 9 stop
  bit_cnt_t bit_cnt;
  byte_t    rx_shift;
  // strobes for the payload registers
  logic     shift_en;
  logic     load_en;

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end else begin
      rx_meta <= i_rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  // data bit sample point, mid bit
  assign shift_en = rx_busy && i_os_tick && (os_cnt == os_cnt_t'(OS_RATE - 1)) &&
                    (bit_cnt != '0) && (bit_cnt != bit_cnt_t'(9));
  // stop bit sample point with a good stop bit
  assign load_en  = rx_busy && i_os_tick && (os_cnt == os_cnt_t'(OS_RATE - 1)) &&
                    (bit_cnt == bit_cnt_t'(9)) && rx_sync;

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      rx_busy     <= 1'b0;
      os_cnt      <= '0;
      bit_cnt     <= '0;
      o_rx_valid  <= 1'b0;
      o_frame_err <= 1'b0;
    end else begin
      o_rx_valid  <= 1'b0;
      o_frame_err <= 1'b0;
      if (!rx_busy) begin
        // falling edge on the line starts a frame
        if (rx_prev && !rx_sync) begin
          rx_busy <= 1'b1;
          os_cnt  <= '0;
          bit_cnt <= '0;
        end
      end else if (i_os_tick) begin
        os_cnt <= os_cnt + 1'b1;
        if (bit_cnt == '0) begin
          // half a bit into the start bit
          if (os_cnt == os_cnt_t'(OS_RATE / 2 - 1)) begin
            os_cnt <= '0;
            if (rx_sync) begin
              // glitch, line went back high
              rx_busy <= 1'b0;
            end else begin
              bit_cnt <= bit_cnt + 1'b1;
            end
          end
        end else if (os_cnt == os_cnt_t'(OS_RATE - 1)) begin
          // counter wraps to 0 by itself here
          if (bit_cnt == bit_cnt_t'(9)) begin
            rx_busy     <= 1'b0;
            o_rx_valid  <= rx_sync;
            o_frame_err <= !rx_sync;
          end else begin
            bit_cnt <= bit_cnt + 1'b1;
          end
        end
      end
    end
  end

  // lsb arrives first, shift in from the top
  always_ff @(posedge clk) begin
    if (shift_en) begin
      rx_shift <= {rx_sync, rx_shift[7:1]};
    end
    if (load_en) begin
      o_rx_data <= rx_shift;
    end
  end

endmodule

`default_nettype wire

/* uart/uart_tx.sv */
`timescale 1ns/10ps
`default_nettype none

module uart_tx (
  input  logic              clk,
  input  logic              i_arst_n,
  input  logic              i_os_tick,
  input  logic              i_tx_start,
  input  periph_pkg::byte_t i_tx_data,
  output logic              o_tx,
  output logic              o_tx_busy
);

  import periph_pkg::*;

  // free-running tick counter, one wrap per bit
  os_cnt_t  os_cnt;
  logic     bit_edge;
  // bits already driven onto the line
  bit_cnt_t bit_cnt;
  // stop, data, start with start in bit 0
  logic [$bits(byte_t)+1:0] tx_shift;

  assign bit_edge = i_os_tick && (os_cnt == os_cnt_t'(OS_RATE - 1));

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      os_cnt <= '0;
    end else if (i_os_tick) begin
      os_cnt <= os_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_tx      <= 1'b1;
      o_tx_busy <= 1'b0;
      bit_cnt   <= '0;
    end else begin
      if (i_tx_start) begin
        // frame waits for the next bit boundary
        o_tx_busy <= 1'b1;
        bit_cnt   <= '0;
      end else if (o_tx_busy && bit_edge) begin
        if (bit_cnt == bit_cnt_t'(10)) begin
          // stop bit has run its full bit time
          o_tx_busy <= 1'b0;
          o_tx      <= 1'b1;
        end else begin
          o_tx    <= tx_shift[0];
          bit_cnt <= bit_cnt + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (i_tx_start) begin
      tx_shift <= {1'b1, i_tx_data, 1'b0};
    end else if (o_tx_busy && bit_edge) begin
      // fill with idle level behind the frame
      tx_shift <= {1'b1, tx_shift[$bits(tx_shift)-1:1]};
    end
  end

endmodule

`default_nettype wire

/* hdl/cmd_fsm.sv */
`timescale 1ns/10ps
`default_nettype none

module cmd_fsm (
  input  logic              clk,
  input  logic              i_arst_n,
  input  periph_pkg::byte_t i_rx_data,
  input  logic              i_rx_valid,
  input  logic              i_frame_err,
  input  periph_pkg::led_t  i_led,
  input  periph_pkg::sw_t   i_sw,
  input  logic              i_tx_busy,
  output logic              o_led_we,
  output periph_pkg::led_t  o_led_wdata,
  output logic              o_tx_start,
  output periph_pkg::byte_t o_tx_data
);

  import periph_pkg::*;

  cmd_state_t state;
  // reply register load strobe and value
  logic       rsp_load;
  byte_t      rsp_next;

  // choose the reply for the byte on the rx bus
  always_comb begin
    rsp_load = 1'b0;
    rsp_next = RSP_NAK;
    if (i_rx_valid) begin
      if (state == ST_IDLE) begin
        rsp_load = (i_rx_data != CMD_LED_WR);
        case (i_rx_data)
          CMD_LED_RD: rsp_next = i_led;
          CMD_SW_RD:  rsp_next = byte_t'(i_sw);
          default:    rsp_next = RSP_NAK;
        endcase
      end else if (state == ST_WAIT_DATA) begin
        // data byte of a led write
        rsp_load = 1'b1;
        rsp_next = RSP_ACK;
      end
    end
  end

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      state      <= ST_IDLE;
      o_led_we   <= 1'b0;
      o_tx_start <= 1'b0;
    end else begin
      // strobes last one clock
      o_led_we   <= 1'b0;
      o_tx_start <= 1'b0;
      case (state)
        ST_IDLE: begin
          if (i_rx_valid) begin
            if (i_rx_data == CMD_LED_WR) begin
              state <= ST_WAIT_DATA;
            end else begin
              state <= ST_SEND;
            end
          end
        end
        ST_WAIT_DATA: begin
          // a bad frame aborts the write
          if (i_frame_err) begin
            state <= ST_IDLE;
          end else if (i_rx_valid) begin
            o_led_we <= 1'b1;
            state    <= ST_SEND;
          end
        end
        ST_SEND: begin
          if (!i_tx_busy) begin
            o_tx_start <= 1'b1;
            state      <= ST_WAIT_TX;
          end
        end
        ST_WAIT_TX: begin
          // busy rises one clock after start, skip that clock
          if (!o_tx_start && !i_tx_busy) begin
            state <= ST_IDLE;
          end
        end
        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rsp_load) begin
      o_tx_data <= rsp_next;
    end
    if (state == ST_WAIT_DATA && i_rx_valid) begin
      o_led_wdata <= i_rx_data;
    end
  end

endmodule

`default_nettype wire

/* hdl/gpio_regs.sv */
`timescale 1ns/10ps
`default_nettype none

module gpio_regs (
  input  logic             clk,
  input  logic             i_arst_n,
  input  logic             i_led_we,
  input  periph_pkg::led_t i_led_wdata,
  input  periph_pkg::sw_t  i_sw,
  output periph_pkg::led_t o_led,
  output periph_pkg::sw_t  o_sw_sync
);

  import periph_pkg::*;

  // first synchronizer stage, may go metastable
  sw_t sw_meta;

  // led register, written by the decoder
  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_led <= '0;
    end else if (i_led_we) begin
      o_led <= i_led_wdata;
    end
  end

  // switches are asynchronous to clk
  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      sw_meta   <= '0;
      o_sw_sync <= '0;
    end else begin
      sw_meta   <= i_sw;
      o_sw_sync <= sw_meta;
    end
  end

endmodule

`default_nettype wire

/* hdl/periph_top.sv */
`timescale 1ns/10ps
`default_nettype none

module periph_top (
  input  logic             clk,
  input  logic             i_arst_n,
  input  logic             i_uart_rx,
  output logic             o_uart_tx,
  input  periph_pkg::sw_t  i_sw,
  output periph_pkg::led_t o_led
);

  import periph_pkg::*;

  // shared oversample tick
  logic  os_tick;
  // receiver to decoder
  byte_t rx_data;
  logic  rx_valid;
  logic  frame_err;
  // decoder to led register
  logic  led_we;
  led_t  led_wdata;
  sw_t   sw_sync;
  // decoder to transmitter
  logic  tx_start;
  byte_t tx_data;
  logic  tx_busy;

  baud_timer u_baud_timer (
    .clk       (clk),
    .i_arst_n  (i_arst_n),
    .o_os_tick (os_tick)
  );

  uart_rx u_uart_rx (
    .clk         (clk),
    .i_arst_n    (i_arst_n),
    .i_os_tick   (os_tick),
    .i_rx        (i_uart_rx),
    .o_rx_data   (rx_data),
    .o_rx_valid  (rx_valid),
    .o_frame_err (frame_err)
  );

  // led value goes both to the pins and back for read commands
  cmd_fsm u_cmd_fsm (
    .clk         (clk),
    .i_arst_n    (i_arst_n),
    .i_rx_data   (rx_data),
    .i_rx_valid  (rx_valid),
    .i_frame_err (frame_err),
    .i_led       (o_led),
    .i_sw        (sw_sync),
    .i_tx_busy   (tx_busy),
    .o_led_we    (led_we),
    .o_led_wdata (led_wdata),
    .o_tx_start  (tx_start),
    .o_tx_data   (tx_data)
  );

  gpio_regs u_gpio_regs (
    .clk         (clk),
    .i_arst_n    (i_arst_n),
    .i_led_we    (led_we),
    .i_led_wdata (led_wdata),
    .i_sw        (i_sw),
    .o_led       (o_led),
    .o_sw_sync   (sw_sync)
  );

  uart_tx u_uart_tx (
    .clk        (clk),
    .i_arst_n   (i_arst_n),
    .i_os_tick  (os_tick),
    .i_tx_start (tx_start),
    .i_tx_data  (tx_data),
    .o_tx       (o_uart_tx),
    .o_tx_busy  (tx_busy)
  );

endmodule

`default_nettype wire

/* tb/periph_props.sv */
`timescale 1ns/10ps
`default_nettype none

module periph_props (
  input logic                   clk,
  input logic                   i_arst_n,
  input periph_pkg::cmd_state_t i_state,
  input logic                   i_tx_start,
  input logic                   i_tx_busy,
  input logic                   i_led_we
);

  import periph_pkg::*;

  // a new frame may only be launched while the transmitter is idle
  start_when_idle: assert property (@(posedge clk) disable iff (!i_arst_n)
    $rose(i_tx_start) |-> !i_tx_busy)
    else $error("tx start strobe raised while the transmitter was busy");

  // led write strobe is registered out of the data wait state
  led_we_from_data: assert property (@(posedge clk) disable iff (!i_arst_n)
    i_led_we |-> ($past(i_state) == ST_WAIT_DATA))
    else $error("led write strobe outside the data wait state");

  // transmitter answers a start strobe with busy one clock later
  busy_after_start: assert property (@(posedge clk) disable iff (!i_arst_n)
    i_tx_start |=> i_tx_busy)
    else $error("transmitter busy did not follow the start strobe");

endmodule

bind cmd_fsm periph_props u_props (
  .clk        (clk),
  .i_arst_n   (i_arst_n),
  .i_state    (state),
  .i_tx_start (o_tx_start),
  .i_tx_busy  (i_tx_busy),
  .i_led_we   (o_led_we)
);

`default_nettype wire

/* tb/periph_top_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module periph_top_tb;

  // host side serial timing of 4 clocks per tick and 16 ticks per bit
  localparam int BIT_CLKS   = 64;
  localparam int FRAME_CLKS = 10 * BIT_CLKS;

  // command and reply codes as the host sees them
  localparam logic [7:0] C_LED_WR = 8'h4C;
  localparam logic [7:0] C_LED_RD = 8'h52;
  localparam logic [7:0] C_SW_RD  = 8'h53;
  localparam logic [7:0] C_ACK    = 8'h06;
  localparam logic [7:0] C_NAK    = 8'h15;
  // a byte outside the command set
  localparam logic [7:0] C_BOGUS  = 8'hA5;

  logic       clk = 1'b0;
  logic       i_arst_n;
  logic       i_uart_rx;
  logic       o_uart_tx;
  logic [3:0] i_sw;
  logic [7:0] o_led;

  int         errors;
  int         checks;
  // value the led register should hold
  logic [7:0] last_led;

  periph_top uut (
    .clk       (clk),
    .i_arst_n  (i_arst_n),
    .i_uart_rx (i_uart_rx),
    .o_uart_tx (o_uart_tx),
    .i_sw      (i_sw),
    .o_led     (o_led)
  );

  always #5 clk = ~clk;

  task automatic check_value(input string name, input logic [7:0] exp, input logic [7:0] act);
    checks++;
    assert (act === exp) else begin
      errors++;
      $display("** Error %s: expected 0x%02h, actual 0x%02h", name, exp, act);
    end
  endtask

  // one 8N1 frame sent lsb first with a selectable stop bit level
  task automatic send_byte(input logic [7:0] data, input logic stop_bit);
    logic [9:0] frame;
    int         i;
    frame = {stop_bit, data, 1'b0};
    for (i = 0; i < 10; i++) begin
      @(posedge clk);
      #1;
      i_uart_rx = frame[i];
      repeat (BIT_CLKS - 1) @(posedge clk);
    end
    // back to idle after a bad stop bit
    @(posedge clk);
    #1;
    i_uart_rx = 1'b1;
  endtask

  // outputs are sampled on the falling clock edge away from updates
  task automatic recv_byte(input string name, input int max_clks,
                           output logic [7:0] data, output logic got);
    int wait_clks;
    int i;
    data      = '0;
    got       = 1'b0;
    wait_clks = 0;
    @(negedge clk);
    while (o_uart_tx !== 1'b0 && wait_clks < max_clks) begin
      @(negedge clk);
      wait_clks++;
    end
    if (o_uart_tx === 1'b0) begin
      got = 1'b1;
      // middle of the start bit
      repeat (BIT_CLKS / 2) @(negedge clk);
      for (i = 0; i < 8; i++) begin
        repeat (BIT_CLKS) @(negedge clk);
        data[i] = o_uart_tx;
      end
      repeat (BIT_CLKS) @(negedge clk);
      checks++;
      assert (o_uart_tx === 1'b1) else begin
        errors++;
        $display("%s: the reply frame had a low stop bit", name);
      end
      // let the stop bit finish so the decoder is idle again
      repeat (BIT_CLKS / 2 + 4) @(negedge clk);
    end
  endtask

  // the reply may start before the command's stop bit ends so the host listens in parallel
  task automatic run_command(input string name, input logic [7:0] cmd, input logic with_data,
                             input logic [7:0] data, input logic [7:0] exp_rsp);
    logic [7:0] rsp;
    logic       got;
    fork
      begin
        send_byte(cmd, 1'b1);
        if (with_data) begin
          send_byte(data, 1'b1);
        end
      end
      recv_byte(name, 3 * FRAME_CLKS, rsp, got);
    join
    if (got) begin
      check_value(name, exp_rsp, rsp);
    end else begin
      checks++;
      errors++;
      $display("%s: timed out waiting for the reply start bit", name);
    end
  endtask

  task automatic test_reset();
    int i;
    // line idle high and leds dark
    for (i = 0; i < 100; i++) begin
      @(negedge clk);
      check_value("test_reset", 8'h01, {7'b0, o_uart_tx});
      check_value("test_reset", 8'h00, o_led);
    end
  endtask

  task automatic test_led_write();
    logic [7:0] d;
    int         n;
    for (n = 0; n < 4; n++) begin
      d = 8'($urandom);
      run_command("test_led_write", C_LED_WR, 1'b1, d, C_ACK);
      @(negedge clk);
      check_value("test_led_write", d, o_led);
      last_led = d;
    end
  endtask

  task automatic test_led_read();
    logic [7:0] d;
    d = 8'($urandom);
    run_command("test_led_read", C_LED_WR, 1'b1, d, C_ACK);
    last_led = d;
    // read back must return the value just written
    run_command("test_led_read", C_LED_RD, 1'b0, 8'h00, last_led);
  endtask

  task automatic test_switch_read();
    logic [3:0] sw;
    int         n;
    for (n = 0; n < 3; n++) begin
      sw = 4'($urandom);
      @(posedge clk);
      #1;
      i_sw = sw;
      // two synchronizer stages plus margin
      repeat (10) @(posedge clk);
      run_command("test_switch_read", C_SW_RD, 1'b0, 8'h00, {4'h0, sw});
    end
  endtask

  task automatic test_errors();
    logic [7:0] rsp;
    logic       got;
    run_command("test_errors", C_BOGUS, 1'b0, 8'h00, C_NAK);
    // led write whose data byte has a bad stop bit
    fork
      begin
        send_byte(C_LED_WR, 1'b1);
        send_byte(~last_led, 1'b0);
      end
      recv_byte("test_errors", 5 * FRAME_CLKS, rsp, got);
    join
    checks++;
    assert (!got) else begin
      errors++;
      $display("test_errors: got reply 0x%02h after a framing error, expected none", rsp);
    end
    @(negedge clk);
    check_value("test_errors", last_led, o_led);
    run_command("test_errors", C_LED_RD, 1'b0, 8'h00, last_led);
  endtask

  initial begin
    void'($urandom(32'h7b1e));
    errors    = 0;
    checks    = 0;
    last_led  = '0;
    i_arst_n  = 1'b0;
    i_uart_rx = 1'b1;
    i_sw      = '0;
    repeat (2) @(posedge clk);
    #1;
    i_arst_n = 1'b1;

    test_reset();
    test_led_write();
    test_led_read();
    test_switch_read();
    test_errors();

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* list.f */
common/periph_pkg.sv
hdl/baud_timer.sv
uart/uart_rx.sv
uart/uart_tx.sv
hdl/cmd_fsm.sv
hdl/gpio_regs.sv
hdl/periph_top.sv
tb/periph_props.sv
tb/periph_top_tb.sv

/* run.sh */
#!/bin/sh
# build and run the periph_top testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module periph_top_tb -f list.f -o periph_sim

# a failing assertion may stop the simulator early, the search decides
out=$(./obj_dir/periph_sim 2>&1) || true
echo "$out"

if echo "$out" | grep -qF '*** PASSED ***'; then
  exit 0
else
  exit 1
fi
